// File: include/his_settings.svh
`ifndef HIS_SETTINGS_SVH
`define HIS_SETTINGS_SVH

// bin address width, 16 bins
`define HIS_NB 4
`define HIS_BIN_NUM 16

// bin counter width, saturates at all ones
`define HIS_COUNT_W 4

// nested frame loop sizes
// events per pixel
`define HIS_DATA_NUM 2
// pixels per acquisition
`define HIS_PIXEL_NUM 4
// acquisitions per frame, 24 events in total
`define HIS_ACQ_NUM 3

// completed frame counter width
`define HIS_FRAME_W 8

// apb bus widths
`define HIS_APB_AW 12
`define HIS_APB_DW 32

`endif

// File: logic/his_pkg.sv
`include "his_settings.svh"

package his_pkg;

    // bin address into one bank
    typedef logic [`HIS_NB-1:0] bin_t;

    // value held by one bin counter
    typedef logic [`HIS_COUNT_W-1:0] count_t;

    // number of finished frames, wraps
    typedef logic [`HIS_FRAME_W-1:0] frame_cnt_t;

    // apb vectors
    typedef logic [`HIS_APB_AW-1:0] apb_addr_t;
    typedef logic [`HIS_APB_DW-1:0] apb_data_t;

    // builder fsm
    typedef enum logic [1:0] {
        // zeroing the active bank
        st_clear,
        // taking events
        st_count,
        // last write of the frame still pending
        st_drain
    } builder_state_t;

endpackage

// File: logic/his_bin_ram.sv
`timescale 1ns/10ps
`include "his_settings.svh"

module his_bin_ram import his_pkg::*; (
    input  logic   clk,
    input  logic   bank,
    input  bin_t   rd_bin,
    output count_t rd_count,
    input  logic   wr_en,
    input  bin_t   wr_bin,
    input  count_t wr_count,
    input  logic   clr_en,
    input  bin_t   clr_bin,
    input  bin_t   ro_bin,
    output count_t ro_count
);

    // two banks, one filling and one held for readout
    count_t mem [0:1][0:`HIS_BIN_NUM-1];

    // readout always looks at the finished bank
    logic ro_bank;

    assign ro_bank = ~bank;

    // counting port on the active bank
    always_ff @(posedge clk) begin
        // clear wins, the builder never overlaps the two
        if (clr_en) begin
            mem[bank][clr_bin] <= '0;
        end else if (wr_en) begin
            mem[bank][wr_bin] <= wr_count;
        end
        // read returns the value before a same-edge write
        rd_count <= mem[bank][rd_bin];
    end

    // registered readout port
    always_ff @(posedge clk) begin
        ro_count <= mem[ro_bank][ro_bin];
    end

endmodule

// File: logic/his_builder_fsm.sv
`timescale 1ns/10ps
`include "his_settings.svh"

module his_builder_fsm import his_pkg::*; (
    input  logic       clk,
    input  logic       res,
    input  logic       ev_valid,
    input  bin_t       ev_bin,
    output logic       ev_ready,
    output bin_t       rd_bin,
    input  count_t     rd_count,
    output logic       wr_en,
    output bin_t       wr_bin,
    output count_t     wr_count,
    output logic       clr_en,
    output bin_t       clr_bin,
    output logic       his_num,
    output logic       frame_done,
    output frame_cnt_t frame_cnt
);

    // loop counter widths, at least one bit each
    localparam int IN_W  = (`HIS_DATA_NUM  > 1) ? $clog2(`HIS_DATA_NUM)  : 1;
    localparam int PIX_W = (`HIS_PIXEL_NUM > 1) ? $clog2(`HIS_PIXEL_NUM) : 1;
    localparam int ACQ_W = (`HIS_ACQ_NUM   > 1) ? $clog2(`HIS_ACQ_NUM)   : 1;

    localparam count_t COUNT_MAX = '1;

    builder_state_t state, state_nxt;

    logic             accept;
    logic [IN_W-1:0]  in_cnt;
    logic [PIX_W-1:0] pix_cnt;
    logic [ACQ_W-1:0] acq_cnt;
    logic             in_last, pix_last, acq_last, frame_last;
    bin_t             clr_cnt;
    logic             clr_last;

    // read stage, bin read issued one cycle earlier
    logic   p1_valid;
    bin_t   p1_bin;
    // last write, kept for forwarding
    logic   w_valid;
    bin_t   w_bin;
    count_t w_count;
    logic   fwd_hit;
    count_t base;

    assign ev_ready = (state == st_count);
    assign accept   = ev_valid & ev_ready;

    // inner loops of the frame
    assign in_last    = (in_cnt  == IN_W'(`HIS_DATA_NUM - 1));
    assign pix_last   = (pix_cnt == PIX_W'(`HIS_PIXEL_NUM - 1));
    assign acq_last   = (acq_cnt == ACQ_W'(`HIS_ACQ_NUM - 1));
    assign frame_last = in_last & pix_last & acq_last;

    assign clr_last = (clr_cnt == bin_t'(`HIS_BIN_NUM - 1));
    assign clr_en   = (state == st_clear);
    assign clr_bin  = clr_cnt;

    // bin read goes out in the acceptance cycle
    assign rd_bin = ev_bin;

    // ram value is stale if the previous event just wrote this bin
    assign fwd_hit  = w_valid & (w_bin == p1_bin);
    assign base     = fwd_hit ? w_count : rd_count;
    assign wr_en    = p1_valid;
    assign wr_bin   = p1_bin;
    // saturating increment
    assign wr_count = (base == COUNT_MAX) ? COUNT_MAX : base + 1'b1;

    always_comb begin
        state_nxt = state;
        case (state)
            st_clear: begin
                if (clr_last) begin
                    state_nxt = st_count;
                end
            end
            st_count: begin
                if (accept && frame_last) begin
                    state_nxt = st_drain;
                end
            end
            // write of the last event lands here
            st_drain: state_nxt = st_clear;
            default:  state_nxt = st_clear;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= st_clear;
            clr_cnt    <= '0;
            his_num    <= 1'b0;
            frame_done <= 1'b0;
            frame_cnt  <= '0;
        end else begin
            state <= state_nxt;
            if (state == st_clear) begin
                clr_cnt <= clr_last ? '0 : clr_cnt + 1'b1;
            end
            // swap banks once the frame is complete in ram
            frame_done <= (state == st_drain);
            if (state == st_drain) begin
                his_num   <= ~his_num;
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    // events per pixel, pixels per acq, acqs per frame
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            in_cnt  <= '0;
            pix_cnt <= '0;
            acq_cnt <= '0;
        end else if (accept) begin
            if (in_last) begin
                in_cnt <= '0;
                if (pix_last) begin
                    pix_cnt <= '0;
                    acq_cnt <= acq_last ? '0 : acq_cnt + 1'b1;
                end else begin
                    pix_cnt <= pix_cnt + 1'b1;
                end
            end else begin
                in_cnt <= in_cnt + 1'b1;
            end
        end
    end

    // pipeline valids
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            p1_valid <= 1'b0;
            w_valid  <= 1'b0;
        end else begin
            p1_valid <= accept;
            w_valid  <= p1_valid;
        end
    end

    // pipeline payload
    always_ff @(posedge clk) begin
        p1_bin  <= ev_bin;
        w_bin   <= p1_bin;
        w_count <= wr_count;
    end

endmodule

// File: logic/his_apb_readout.sv
`timescale 1ns/10ps
`include "his_settings.svh"

module his_apb_readout import his_pkg::*; (
    input  logic       clk,
    input  logic       res,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  apb_addr_t  paddr,
    output logic       pready,
    output apb_data_t  prdata,
    output logic       pslverr,
    output bin_t       ro_bin,
    input  count_t     ro_count,
    input  logic       his_num,
    input  frame_cnt_t frame_cnt
);

    // address map
    localparam apb_addr_t STATUS_ADDR = 'h000;
    localparam apb_addr_t BIN_BASE    = 'h100;
    // one word per bin
    localparam int BIN_SHIFT = `HIS_NB + 2;

    logic      acc_first;
    logic      is_status;
    logic      is_bin;
    logic      err;
    apb_data_t rd_data;

    // bin index from word address, ram sees it in setup
    assign ro_bin = paddr[BIN_SHIFT-1:2];

    // first access cycle, the wait state
    assign acc_first = psel & penable & ~pready;

    assign is_status = (paddr == STATUS_ADDR);
    // window of BIN_NUM words at BIN_BASE, word aligned only
    assign is_bin = ((paddr >> BIN_SHIFT) == (BIN_BASE >> BIN_SHIFT))
                    && (paddr[1:0] == 2'b00);

    // read only space
    assign err = pwrite | ~(is_status | is_bin);

    always_comb begin
        rd_data = '0;
        if (!err) begin
            if (is_status) begin
                // his_num above frame count
                rd_data = apb_data_t'({his_num, frame_cnt});
            end else begin
                rd_data = apb_data_t'(ro_count);
            end
        end
    end

    // response registered, so it shows in the second access cycle
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
            prdata  <= '0;
        end else if (acc_first) begin
            pready  <= 1'b1;
            pslverr <= err;
            prdata  <= rd_data;
        end else begin
            // back to idle after the completing cycle
            pready  <= 1'b0;
            pslverr <= 1'b0;
            prdata  <= '0;
        end
    end

endmodule

// File: logic/his_top.sv
`timescale 1ns/10ps

module his_top import his_pkg::*; (
    input  logic      clk,
    input  logic      res,
    input  logic      ev_valid,
    input  bin_t      ev_bin,
    output logic      ev_ready,
    output logic      frame_done,
    output logic      his_num,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    output logic      pready,
    output apb_data_t prdata,
    output logic      pslverr
);

    // counting port
    bin_t       rd_bin;
    count_t     rd_count;
    logic       wr_en;
    bin_t       wr_bin;
    count_t     wr_count;
    logic       clr_en;
    bin_t       clr_bin;
    // readout port
    bin_t       ro_bin;
    count_t     ro_count;
    frame_cnt_t frame_cnt;

    his_builder_fsm i_builder (
        .clk        (clk),
        .res        (res),
        .ev_valid   (ev_valid),
        .ev_bin     (ev_bin),
        .ev_ready   (ev_ready),
        .rd_bin     (rd_bin),
        .rd_count   (rd_count),
        .wr_en      (wr_en),
        .wr_bin     (wr_bin),
        .wr_count   (wr_count),
        .clr_en     (clr_en),
        .clr_bin    (clr_bin),
        .his_num    (his_num),
        .frame_done (frame_done),
        .frame_cnt  (frame_cnt)
    );

    // active bank follows his_num
    his_bin_ram i_ram (
        .clk      (clk),
        .bank     (his_num),
        .rd_bin   (rd_bin),
        .rd_count (rd_count),
        .wr_en    (wr_en),
        .wr_bin   (wr_bin),
        .wr_count (wr_count),
        .clr_en   (clr_en),
        .clr_bin  (clr_bin),
        .ro_bin   (ro_bin),
        .ro_count (ro_count)
    );

    his_apb_readout i_readout (
        .clk       (clk),
        .res       (res),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pready    (pready),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .ro_bin    (ro_bin),
        .ro_count  (ro_count),
        .his_num   (his_num),
        .frame_cnt (frame_cnt)
    );

endmodule

// File: bench/his_sva.sv
`timescale 1ns/10ps

module his_sva (
    input logic clk,
    input logic res,
    input logic ev_ready,
    input logic frame_done,
    input logic his_num,
    input logic psel,
    input logic penable,
    input logic pready
);

    // number of failed properties so far
    int fail_cnt = 0;

    // frame end pulse is a single cycle
    a_done_pulse: assert property (@(posedge clk) disable iff (!res)
        frame_done |=> !frame_done)
        else begin
            fail_cnt++;
            $error("frame_done high for more than one cycle");
        end

    // bank swap only together with frame_done
    a_num_swap: assert property (@(posedge clk) disable iff (!res)
        $changed(his_num) |-> frame_done)
        else begin
            fail_cnt++;
            $error("his_num changed outside a frame_done cycle");
        end

    // new bank is being cleared
    a_ready_after_done: assert property (@(posedge clk) disable iff (!res)
        frame_done |=> !ev_ready)
        else begin
            fail_cnt++;
            $error("ev_ready high in the cycle after frame_done");
        end

    // one wait state, then completion
    a_pready_access: assert property (@(posedge clk) disable iff (!res)
        pready |-> (psel && penable && $past(psel && penable)))
        else begin
            fail_cnt++;
            $error("pready high outside the second access cycle");
        end

    // quiet outputs right after reset release
    a_reset_idle: assert property (@(posedge clk)
        $rose(res) |-> (!ev_ready && !frame_done && !pready))
        else begin
            fail_cnt++;
            $error("outputs not idle after reset release");
        end

endmodule

bind his_top his_sva i_sva (
    .clk        (clk),
    .res        (res),
    .ev_ready   (ev_ready),
    .frame_done (frame_done),
    .his_num    (his_num),
    .psel       (psel),
    .penable    (penable),
    .pready     (pready)
);

// File: bench/his_tb.sv
`timescale 1ns/10ps
`include "his_settings.svh"

module his_tb import his_pkg::*; ();

    // events per frame from the nested loop sizes
    localparam int FRAME_EV = `HIS_DATA_NUM * `HIS_PIXEL_NUM * `HIS_ACQ_NUM;
    localparam int TIMEOUT  = 200;
    localparam count_t SAT  = {`HIS_COUNT_W{1'b1}};

    logic clk, res, ev_valid, ev_ready, frame_done, his_num;
    logic psel, penable, pwrite, pready, pslverr;
    bin_t ev_bin;
    apb_addr_t paddr;
    apb_data_t prdata;

    // reference histogram for both banks
    count_t m_bins [0:1][0:`HIS_BIN_NUM-1];
    logic m_num;
    frame_cnt_t m_frames;
    // last apb response
    apb_data_t rd_val;
    logic rd_err;

    his_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_fail(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input apb_data_t exp, input apb_data_t act);
        assert (act === exp)
            else stop_fail($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    endtask

    // protocol checks bound into the dut
    always @(i_dut.i_sva.fail_cnt) begin
        if (i_dut.i_sva.fail_cnt != 0) begin
            stop_fail("protocol assertion failed");
        end
    end

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ev_ready) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) stop_fail("timeout waiting for ev_ready");
        end
    endtask

    // valid stays high afterwards so the next call is back to back
    task automatic send_event(input bin_t b);
        ev_valid = 1'b1;
        ev_bin   = b;
        wait_ready();
        @(posedge clk);
        #1;
        // taken at this edge with a saturating count
        if (m_bins[m_num][b] != SAT) m_bins[m_num][b] = m_bins[m_num][b] + 1'b1;
    endtask

    task automatic idle(input int cycles);
        ev_valid = 1'b0;
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_frame_done();
        int n;
        n = 0;
        while (!frame_done) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) stop_fail("timeout waiting for frame_done");
        end
        // swap so the new active bank starts empty
        m_num = ~m_num;
        m_frames++;
        for (int i = 0; i < `HIS_BIN_NUM; i++) m_bins[m_num][i] = '0;
        check_val("his_num", apb_data_t'(m_num), apb_data_t'(his_num));
    endtask

    task automatic apb_access(input apb_addr_t a, input logic wr);
        int n;
        n = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        @(posedge clk);
        #1;
        penable = 1'b1;
        while (!pready) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT) stop_fail("timeout waiting for pready");
        end
        // exactly one wait state
        check_val("apb_wait_states", 1, n);
        rd_val = prdata;
        rd_err = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic check_status();
        apb_access('h000, 1'b0);
        check_val("status", apb_data_t'({m_num, m_frames}), rd_val);
        check_val("pslverr", 0, apb_data_t'(rd_err));
    endtask

    // finished bank against the model
    task automatic check_bins();
        for (int i = 0; i < `HIS_BIN_NUM; i++) begin
            apb_access(apb_addr_t'('h100 + 4 * i), 1'b0);
            check_val($sformatf("bin%0d", i), apb_data_t'(m_bins[!m_num][i]), rd_val);
            check_val("pslverr", 0, apb_data_t'(rd_err));
        end
    endtask

    task automatic check_error(input apb_addr_t a, input logic wr);
        apb_access(a, wr);
        check_val("pslverr", 1, apb_data_t'(rd_err));
        check_val("prdata", 0, rd_val);
    endtask

    initial begin
        res = 1'b0;
        ev_valid = 1'b0;
        ev_bin = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        m_num = 1'b0;
        m_frames = '0;
        rd_val = '0;
        rd_err = 1'b0;
        for (int i = 0; i < `HIS_BIN_NUM; i++) begin
            m_bins[0][i] = '0;
            m_bins[1][i] = '0;
        end
        void'($urandom(82));
        repeat (4) @(posedge clk);
        #1;
        res = 1'b1;

        // bank 0 cleared and status idle
        wait_ready();
        check_val("his_num", 0, apb_data_t'(his_num));
        check_status();

        // random bins with random gaps
        for (int i = 0; i < FRAME_EV; i++) begin
            send_event(bin_t'($urandom));
            // frame_done follows the last event within two cycles
            if (i < FRAME_EV - 1) begin
                idle($urandom_range(3, 0));
            end else begin
                idle(0);
            end
        end
        wait_frame_done();
        check_bins();
        check_status();

        // back to back so the same bin hits the forwarding path
        for (int i = 0; i < FRAME_EV; i++) send_event((i < 20) ? bin_t'(3) : bin_t'(7));
        // next event waits through drain and clear
        ev_bin = bin_t'(5);
        wait_frame_done();
        send_event(bin_t'(5));
        idle(0);
        apb_access('h10C, 1'b0);
        check_val("bin3", 15, rd_val);
        apb_access('h11C, 1'b0);
        check_val("bin7", 4, rd_val);

        // third frame part way while the second frame stays readable
        for (int i = 0; i < 9; i++) begin
            send_event(bin_t'($urandom));
            idle($urandom_range(2, 0));
        end
        idle(1);
        check_bins();
        for (int i = 0; i < FRAME_EV - 10; i++) send_event(bin_t'($urandom));
        idle(0);
        wait_frame_done();
        check_bins();
        check_status();

        // unmapped reads and a write
        check_error('h040, 1'b0);
        check_error('h200, 1'b0);
        check_error('h000, 1'b1);
        check_status();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
logic/his_pkg.sv
logic/his_bin_ram.sv
logic/his_builder_fsm.sv
logic/his_apb_readout.sv
logic/his_top.sv
bench/his_sva.sv
bench/his_tb.sv
